//--- hist_config.svh
`ifndef HIST_CONFIG_SVH
`define HIST_CONFIG_SVH

// number of histogram bins
`define HIST_BINS 16
// bin index width, log2 of HIST_BINS
`define BIN_ADDR_W 4
// per-bin counter width, saturates at all ones
`define COUNT_W 8
// raw timestamp width from the TDC
`define TIME_W 10
// low timestamp bits folded into one bin
`define BIN_SHIFT 4

`endif

//--- histPkg.sv
`include "hist_config.svh"

package histPkg;

    // bin index into the histogram memory
    typedef logic [`BIN_ADDR_W-1:0] binAddrT;
    // photon count held per bin
    typedef logic [`COUNT_W-1:0] countT;
    // hit timestamp as delivered by the sensor
    typedef logic [`TIME_W-1:0] timeT;

    // builder sequencing
    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        ACCUM,
        DRAIN,
        SCAN,
        REPORT
    } builderStateT;

    // mapped hit, mapper to builder
    typedef struct packed {
        logic    valid;
        binAddrT bin;
    } binHitT;

    // one bin and its count, used for the output stream and the pending write
    typedef struct packed {
        binAddrT bin;
        countT   count;
    } binEntryT;

    // peak result after a scan
    typedef struct packed {
        binAddrT bin;
        countT   count;
    } peakT;

endpackage

//--- binMapper.sv
`timescale 1ns/1ps
`include "hist_config.svh"

module binMapper (
    input  logic             clk,
    input  logic             res,
    input  logic             hitValid,
    input  histPkg::timeT    hitTime,
    input  logic             accept,
    output histPkg::binHitT  binHit
);

    // timestamp with the sub-bin bits shifted out
    histPkg::timeT    shifted;
    logic             inRange;
    logic             hitVld;
    histPkg::binAddrT hitBin;

    assign shifted = hitTime >> `BIN_SHIFT;

    // anything past the last bin is dropped here
    assign inRange = shifted < histPkg::timeT'(`HIST_BINS);

    // valid only when the builder is accepting hits
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hitVld <= 1'b0;
        end else begin
            hitVld <= hitValid && accept && inRange;
        end
    end

    // bin index, only meaningful with hitVld
    always_ff @(posedge clk) begin
        if (hitValid) begin
            hitBin <= shifted[`BIN_ADDR_W-1:0];
        end
    end

    assign binHit.valid = hitVld;
    assign binHit.bin   = hitBin;

endmodule

//--- histRam.sv
`timescale 1ns/1ps
`include "hist_config.svh"

module histRam (
    input  logic             clk,
    input  logic             wrEn,
    input  histPkg::binAddrT wrAddr,
    input  histPkg::countT   wrData,
    input  histPkg::binAddrT rdAddr,
    output histPkg::countT   rdData
);

    // one counter per bin
    histPkg::countT mem [0:`HIST_BINS-1];

    // write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read port
    // same-address write in this cycle is not visible yet (read-first),
    // the builder forwards around that case
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];
    end

endmodule

//--- histBuilder.sv
`timescale 1ns/1ps
`include "hist_config.svh"

module histBuilder (
    input  logic               clk,
    input  logic               res,
    input  logic               start,
    input  logic               frameEnd,
    input  histPkg::binHitT    binHit,
    input  histPkg::countT     rdData,
    output logic               ready,
    output histPkg::binAddrT   rdAddr,
    output logic               wrEn,
    output histPkg::binAddrT   wrAddr,
    output histPkg::countT     wrData,
    output histPkg::binEntryT  scanEntry,
    output logic               scanValid,
    output logic               scanFirst,
    output logic               done
);

    // last bin index, end of clear and scan
    localparam histPkg::binAddrT LastBin = histPkg::binAddrT'(`HIST_BINS - 1);
    // drain lasts three cycles, counter 0 to 2
    localparam histPkg::binAddrT DrainLast = histPkg::binAddrT'(2);

    histPkg::builderStateT state;
    histPkg::builderStateT stateNext;
    // shared counter for clear address, drain length and scan address
    histPkg::binAddrT      addrCnt;

    // increment pipeline
    logic                  accActive;
    logic                  s1Valid;
    histPkg::binAddrT      s1Bin;
    logic                  accWr;
    histPkg::binEntryT     pend;
    logic                  pendValid;
    histPkg::countT        baseCount;
    histPkg::countT        incCount;

    // bin of the read issued in the previous scan cycle
    histPkg::binAddrT      scanBin;

    always_comb begin
        stateNext = state;
        case (state)
            histPkg::CLEAR: begin
                if (addrCnt == LastBin) begin
                    stateNext = histPkg::ACCUM;
                end
            end
            histPkg::ACCUM: begin
                if (frameEnd) begin
                    stateNext = histPkg::DRAIN;
                end
            end
            histPkg::DRAIN: begin
                if (addrCnt == DrainLast) begin
                    stateNext = histPkg::SCAN;
                end
            end
            histPkg::SCAN: begin
                if (addrCnt == LastBin) begin
                    stateNext = histPkg::REPORT;
                end
            end
            histPkg::REPORT: stateNext = histPkg::IDLE;
            default:         stateNext = histPkg::IDLE;
        endcase
        // start wins from any state
        if (start) begin
            stateNext = histPkg::CLEAR;
        end
    end

    // counter restarts on every state change and on start
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state   <= histPkg::IDLE;
            addrCnt <= '0;
        end else begin
            state <= stateNext;
            if (start || stateNext != state) begin
                addrCnt <= '0;
            end else begin
                addrCnt <= addrCnt + 1'b1;
            end
        end
    end

    // hits still land during drain, the last ones are in flight
    assign accActive = (state == histPkg::ACCUM) || (state == histPkg::DRAIN);
    assign accWr     = accActive && s1Valid;

    // rdData is stale if the previous write hit the same bin
    assign baseCount = (pendValid && pend.bin == s1Bin) ? pend.count : rdData;
    // hold at full scale
    assign incCount  = (baseCount == '1) ? baseCount : baseCount + 1'b1;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid   <= 1'b0;
            pendValid <= 1'b0;
            scanValid <= 1'b0;
            scanFirst <= 1'b0;
            done      <= 1'b0;
        end else begin
            s1Valid   <= accActive && binHit.valid;
            pendValid <= accWr;
            // stream lags the read address by the RAM latency
            scanValid <= state == histPkg::SCAN;
            scanFirst <= (state == histPkg::SCAN) && (addrCnt == '0);
            // one cycle after the last streamed bin
            done      <= state == histPkg::REPORT;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin      <= binHit.bin;
        pend.bin   <= s1Bin;
        pend.count <= incCount;
        scanBin    <= addrCnt;
    end

    assign ready  = state == histPkg::ACCUM;

    // read the hit's bin as it arrives, or walk the bins when scanning
    assign rdAddr = (state == histPkg::SCAN) ? addrCnt : binHit.bin;

    // clear owns the write port, otherwise the increment result
    assign wrEn   = (state == histPkg::CLEAR) || accWr;
    assign wrAddr = (state == histPkg::CLEAR) ? addrCnt : s1Bin;
    assign wrData = (state == histPkg::CLEAR) ? '0 : incCount;

    assign scanEntry.bin   = scanBin;
    assign scanEntry.count = rdData;

endmodule

//--- peakFinder.sv
`timescale 1ns/1ps

module peakFinder (
    input  logic              clk,
    input  logic              res,
    input  histPkg::binEntryT scanEntry,
    input  logic              scanValid,
    input  logic              scanFirst,
    output histPkg::peakT     peak
);

    logic takeEntry;
    logic greater;

    // strictly greater only, so an equal count never displaces a lower bin
    assign greater = scanEntry.count > peak.count;

    // first entry always loads and drops the previous frame's peak
    assign takeEntry = scanValid && (scanFirst || greater);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peak <= '0;
        end else if (takeEntry) begin
            peak.bin   <= scanEntry.bin;
            peak.count <= scanEntry.count;
        end
    end

    // held untouched between scans, so the result stays
    // readable from done until the next frame's scan

endmodule

//--- histTop.sv
`timescale 1ns/1ps

module histTop (
    input  logic              clk,
    input  logic              res,
    input  logic              start,
    input  logic              hitValid,
    input  histPkg::timeT     hitTime,
    input  logic              frameEnd,
    output logic              ready,
    output histPkg::binEntryT binOut,
    output logic              binValid,
    output histPkg::peakT     peak,
    output logic              done
);

    // mapper to builder
    histPkg::binHitT   binHit;

    // builder to memory
    histPkg::binAddrT  rdAddr;
    logic              wrEn;
    histPkg::binAddrT  wrAddr;
    histPkg::countT    wrData;
    histPkg::countT    rdData;

    // scan stream, also the external output
    histPkg::binEntryT scanEntry;
    logic              scanValid;
    logic              scanFirst;

    // hits are only taken while the builder accumulates
    binMapper uMapper (
        .clk      (clk),
        .res      (res),
        .hitValid (hitValid),
        .hitTime  (hitTime),
        .accept   (ready),
        .binHit   (binHit)
    );

    histBuilder uBuilder (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .frameEnd  (frameEnd),
        .binHit    (binHit),
        .rdData    (rdData),
        .ready     (ready),
        .rdAddr    (rdAddr),
        .wrEn      (wrEn),
        .wrAddr    (wrAddr),
        .wrData    (wrData),
        .scanEntry (scanEntry),
        .scanValid (scanValid),
        .scanFirst (scanFirst),
        .done      (done)
    );

    histRam uRam (
        .clk    (clk),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

    peakFinder uPeak (
        .clk       (clk),
        .res       (res),
        .scanEntry (scanEntry),
        .scanValid (scanValid),
        .scanFirst (scanFirst),
        .peak      (peak)
    );

    assign binOut   = scanEntry;
    assign binValid = scanValid;

endmodule

//--- hist_checker.sv
`timescale 1ns/1ps
`include "hist_config.svh"

module histChecker (
    input  logic clk,
    input  logic res,
    input  logic start,
    input  logic frameEnd,
    input  logic ready,
    input  logic binValid,
    input  logic done
);

    // consecutive binValid cycles seen before this one
    logic [5:0] runLen;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            runLen <= '0;
        end else if (binValid) begin
            runLen <= runLen + 1'b1;
        end else begin
            runLen <= '0;
        end
    end

    // never more than one full scan in a row
    assert property (@(posedge clk) disable iff (!res)
        binValid |-> runLen < 6'(`HIST_BINS))
        else $error("binValid high for more than one scan");

    // a finished run is exactly one scan long
    assert property (@(posedge clk) disable iff (!res)
        (!binValid && runLen != '0) |-> runLen == 6'(`HIST_BINS))
        else $error("binValid run shorter than one scan");

    // done right after the last bin
    assert property (@(posedge clk) disable iff (!res)
        $fell(binValid) |-> done)
        else $error("done missing after the last bin");

    assert property (@(posedge clk) disable iff (!res)
        done |-> !binValid && $past(binValid))
        else $error("done not aligned to the end of the scan");

    // single cycle pulse
    assert property (@(posedge clk) disable iff (!res)
        done |=> !done)
        else $error("done longer than one cycle");

    // start sends the builder back to clear
    assert property (@(posedge clk) disable iff (!res)
        start |=> !ready)
        else $error("ready high in the cycle after start");

    // frame end closes the hit window on the next cycle
    assert property (@(posedge clk) disable iff (!res)
        ready && frameEnd && !start |=> !ready)
        else $error("ready still high after frame end");

    // no hits taken while the histogram streams out
    assert property (@(posedge clk) disable iff (!res)
        (binValid || done) |-> !ready)
        else $error("ready high during scan or report");

endmodule

bind histTop histChecker uChecker (
    .clk      (clk),
    .res      (res),
    .start    (start),
    .frameEnd (frameEnd),
    .ready    (ready),
    .binValid (binValid),
    .done     (done)
);

//--- histTb.sv
`timescale 1ns/1ps
`include "hist_config.svh"

module histTb;

    // longest any wait may run, in cycles
    localparam integer WaitLimit = 100;
    localparam integer CountMax = (1 << `COUNT_W) - 1;

    logic              clk;
    logic              res;
    logic              start;
    logic              hitValid;
    histPkg::timeT     hitTime;
    logic              frameEnd;
    logic              ready;
    histPkg::binEntryT binOut;
    logic              binValid;
    histPkg::peakT     peak;
    logic              done;

    integer errors;
    integer errMark;
    integer tests;
    integer seed;
    // reference histogram and what the DUT streamed
    integer expCount [0:`HIST_BINS-1];
    integer gotCount [0:`HIST_BINS-1];
    integer expPeakBin;
    integer expPeakCount;
    integer gotPeakBin;
    integer gotPeakCount;

    histTop dut (
        .clk      (clk),
        .res      (res),
        .start    (start),
        .hitValid (hitValid),
        .hitTime  (hitTime),
        .frameEnd (frameEnd),
        .ready    (ready),
        .binOut   (binOut),
        .binValid (binValid),
        .peak     (peak),
        .done     (done)
    );

    always #2 clk = ~clk;

    // inputs change 1 ns after the edge
    task automatic nextCycle;
        @(posedge clk);
        #1;
    endtask

    // reference: shift, drop past the last bin, saturate
    task automatic modelHit(input histPkg::timeT t);
        integer bin;
        bin = int'(t) >> `BIN_SHIFT;
        if (bin < `HIST_BINS) begin
            if (expCount[bin] < CountMax) begin
                expCount[bin]++;
            end
        end
    endtask

    // lowest bin wins ties
    task automatic modelPeak;
        integer i;
        expPeakBin = 0;
        expPeakCount = expCount[0];
        for (i = 1; i < `HIST_BINS; i++) begin
            if (expCount[i] > expPeakCount) begin
                expPeakBin = i;
                expPeakCount = expCount[i];
            end
        end
    endtask

    // one hit per call, calls back to back keep hitValid high
    task automatic sendHit(input histPkg::timeT t);
        hitValid = 1'b1;
        hitTime = t;
        modelHit(t);
        nextCycle;
        hitValid = 1'b0;
    endtask

    task automatic beginFrame;
        integer n;
        integer i;
        start = 1'b1;
        nextCycle;
        start = 1'b0;
        n = 0;
        while (!ready && n < WaitLimit) begin
            nextCycle;
            n++;
        end
        if (!ready) begin
            $display("timeout: ready never rose after start");
            errors++;
        end
        for (i = 0; i < `HIST_BINS; i++) begin
            expCount[i] = 0;
        end
    endtask

    // pulse frameEnd, then collect the stream and the peak
    task automatic endFrame(input string name);
        integer n;
        integer i;
        frameEnd = 1'b1;
        nextCycle;
        frameEnd = 1'b0;
        hitValid = 1'b0;
        n = 0;
        while (!binValid && n < WaitLimit) begin
            nextCycle;
            n++;
        end
        if (!binValid) begin
            $display("%s: timeout, no bins streamed after frame end", name);
            errors++;
        end else begin
            for (i = 0; i < `HIST_BINS; i++) begin
                assert (binValid) else begin
                    $display("%s: binValid dropped before bin %0d", name, i);
                    errors++;
                end
                assert (int'(binOut.bin) == i) else begin
                    $display("[ERROR] %s bin index expected %0d actual %0d",
                        name, i, int'(binOut.bin));
                    errors++;
                end
                gotCount[i] = int'(binOut.count);
                nextCycle;
            end
            n = 0;
            while (!done && n < WaitLimit) begin
                nextCycle;
                n++;
            end
            if (!done) begin
                $display("%s: timeout, done never pulsed", name);
                errors++;
            end
            gotPeakBin = int'(peak.bin);
            gotPeakCount = int'(peak.count);
        end
    endtask

    task automatic checkFrame(input string name);
        integer i;
        for (i = 0; i < `HIST_BINS; i++) begin
            assert (gotCount[i] == expCount[i]) else begin
                $display("[ERROR] %s bin %0d expected %0d actual %0d",
                    name, i, expCount[i], gotCount[i]);
                errors++;
            end
        end
        assert (gotPeakBin == expPeakBin && gotPeakCount == expPeakCount) else begin
            $display("[ERROR] %s peak expected bin %0d count %0d actual bin %0d count %0d",
                name, expPeakBin, expPeakCount, gotPeakBin, gotPeakCount);
            errors++;
        end
    endtask

    task automatic reportTest(input string name);
        tests++;
        if (errors == errMark) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errMark);
        end
        errMark = errors;
    endtask

    // end the frame and check it against the reference
    task automatic closeModelFrame(input string name);
        endFrame(name);
        modelPeak;
        checkFrame(name);
        reportTest(name);
    endtask

    // H hit, E frame end, X expected counts and peak
    task automatic runGolden;
        integer fd;
        integer c;
        integer r;
        integer nRead;
        integer v;
        integer i;
        integer frame;
        logic   inFrame;
        string  name;
        fd = $fopen("hist_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open hist_golden.txt");
            errors++;
        end else begin
            frame = 0;
            inFrame = 1'b0;
            c = $fgetc(fd);
            while (c != -1) begin
                name = $sformatf("golden frame %0d", frame);
                if (c == int'("#")) begin
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else if (c == int'("H")) begin
                    if (!inFrame) begin
                        beginFrame;
                        inFrame = 1'b1;
                    end
                    r = $fscanf(fd, "%h", v);
                    if (r != 1) begin
                        $display("%s: unreadable timestamp in hist_golden.txt", name);
                        errors++;
                    end else begin
                        sendHit(histPkg::timeT'(v));
                    end
                end else if (c == int'("E")) begin
                    if (!inFrame) begin
                        beginFrame;
                    end
                    endFrame(name);
                    inFrame = 1'b0;
                end else if (c == int'("X")) begin
                    // file values replace the reference
                    nRead = 0;
                    for (i = 0; i < `HIST_BINS; i++) begin
                        r = $fscanf(fd, "%d", v);
                        nRead += r;
                        expCount[i] = v;
                    end
                    r = $fscanf(fd, "%d", expPeakBin);
                    nRead += r;
                    r = $fscanf(fd, "%d", expPeakCount);
                    nRead += r;
                    if (nRead != `HIST_BINS + 2) begin
                        $display("%s: incomplete expected line in hist_golden.txt", name);
                        errors++;
                    end
                    checkFrame(name);
                    reportTest(name);
                    frame++;
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
            if (frame == 0) begin
                $display("no expected lines found in hist_golden.txt");
                errors++;
            end
        end
    endtask

    initial begin
        integer i;
        integer r;
        histPkg::timeT t;
        clk = 1'b0;
        res = 1'b0;
        start = 1'b0;
        hitValid = 1'b0;
        hitTime = '0;
        frameEnd = 1'b0;
        errors = 0;
        errMark = 0;
        tests = 0;
        repeat (16) @(posedge clk);
        #1;
        res = 1'b1;
        nextCycle;

        runGolden;

        // empty frame after filled ones, all zero, peak at bin 0
        beginFrame;
        closeModelFrame("clear");

        // same bin every cycle, then two bins alternating
        beginFrame;
        for (i = 0; i < 6; i++) begin
            sendHit(histPkg::timeT'(10'h050 + i));
        end
        for (i = 0; i < 8; i++) begin
            sendHit((i % 2) == 0 ? 10'h023 : 10'h09c);
        end
        // hit in the frameEnd cycle still counts
        hitValid = 1'b1;
        hitTime = 10'h05f;
        modelHit(10'h05f);
        closeModelFrame("back-to-back");

        beginFrame;
        for (i = 0; i < 300; i++) begin
            sendHit(10'h0c3);
        end
        // 256 and up maps past the last bin
        for (i = 0; i < 24; i++) begin
            sendHit(histPkg::timeT'(256 + i * 31));
        end
        closeModelFrame("saturation and range");

        seed = 32'h61cf_5537;
        beginFrame;
        for (i = 0; i < 300; i++) begin
            r = $random(seed);
            if (r[1:0] == 2'b00) begin
                // idle gap
                nextCycle;
            end else begin
                t = histPkg::timeT'(r >>> 8);
                if (r[2]) begin
                    t[9:8] = 2'b00;
                end
                sendHit(t);
            end
        end
        closeModelFrame("random");

        // restart mid frame, bin 4 hits must vanish
        beginFrame;
        for (i = 0; i < 5; i++) begin
            sendHit(10'h041);
        end
        beginFrame;
        for (i = 0; i < 3; i++) begin
            sendHit(10'h06a);
        end
        closeModelFrame("restart");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- hist_golden.txt
# H <timestamp, hex>: one hit, E: frame end
# X <16 bin counts> <peak bin> <peak count>, all decimal
H 005
H 013
H 01f
H 0ff
H 100
H 3ff
H 0a0
H 0a7
H 0af
E
X 1 2 0 0 0 0 0 0 0 0 3 0 0 0 0 1 10 3
H 030
H 031
H 070
H 07e
H 200
E
X 0 0 0 2 0 0 0 2 0 0 0 0 0 0 0 0 3 2
H 0f0
H 0f1
H 0f2
H 0f3
H 0e5
E
X 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 4 15 4

//--- sim.f
+incdir+.
histPkg.sv
binMapper.sv
histRam.sv
histBuilder.sv
peakFinder.sv
histTop.sv
hist_checker.sv
histTb.sv

//--- Makefile
TOP = histTb

compile:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

.PHONY: compile run clean
